// ==== psx_host.f ====
psx_host_pkg.sv
rom_loader.sv
backup_buffer.sv
backup_copy.sv
fb_config.sv
psx_host_top.sv
psx_host_sva.sv
tb_psx_host.sv

// ==== Bender.yml ====
package:
  name: psx_host

sources:
  - psx_host_pkg.sv
  - rom_loader.sv
  - backup_buffer.sv
  - backup_copy.sv
  - fb_config.sv
  - psx_host_top.sv
  - target: test
    files:
      - psx_host_sva.sv
      - tb_psx_host.sv

// ==== tb_psx_host.sv ====
// drives psx_host_top through downloads, core writes, backup copies and video config; RAM acks after 1 to 6 cycles
module tb_psx_host;
	timeunit 1ns;
	timeprecision 1ps;

	// total stimulus words, sizes the watchdog
	localparam int total_words = 8 + 8 + 4 + 32 + 4 * 256 + 40;

	logic        clk_1x;
	logic        rst_n;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic [26:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic        ioctl_wr;
	logic        ioctl_wait;
	logic [26:0] ram_wr_addr;
	logic [31:0] ram_wr_data;
	logic [3:0]  ram_wr_be;
	logic        ram_wr_req;
	logic        ram_wr_ack;
	logic [26:0] core_wr_addr;
	logic [31:0] core_wr_data;
	logic [3:0]  core_wr_be;
	logic        core_wr_req;
	logic        load_exe;
	logic        cart_loaded;
	logic        bk_start;
	logic        bk_loading;
	logic [7:0]  bk_sector;
	logic        bk_req;
	logic [15:0] bk_addr;
	logic [15:0] bk_wdata;
	logic        bk_ack;
	logic [15:0] bk_rdata;
	logic        bk_done;
	logic [7:0]  sd_buff_addr;
	logic [15:0] sd_buff_dout;
	logic        sd_buff_wr;
	logic [15:0] sd_buff_din;
	logic [63:0] status;
	logic [11:0] disp_width;
	logic [11:0] disp_height;
	logic [9:0]  disp_off_x;
	logic [8:0]  disp_off_y;
	logic        forced_scandoubler;
	logic [31:0] fb_base;
	logic [4:0]  fb_format;
	logic [11:0] fb_width;
	logic [11:0] fb_height;
	logic [11:0] arx;
	logic [11:0] ary;
	logic [1:0]  vscale;
	logic [1:0]  scanline;
	logic        hq2x;
	logic        scandoubler;

	integer seed = 4980;
	int     err_cnt, check_cnt, test_cnt, err0, chk0;
	int     wr_cnt, ack_cnt, exe_pulses, bk_idx;
	logic [7:0]  cur_sector;
	// {addr, data, byte enables} per expected RAM write
	logic [62:0] exp_q [$];
	logic [15:0] sd_data [256];
	// backup side of the RAM, keyed by sector and word
	logic [15:0] bk_mem [logic [15:0]];

	psx_host_top i_dut (.*);

	bind rom_loader psx_host_sva i_loader_sva (
		.clk_1x    (clk_1x),
		.rst_n     (rst_n),
		.ram_wr_req(ram_wr_req),
		.ram_wr_ack(ram_wr_ack),
		.ioctl_wait(ioctl_wait),
		.load_exe  (load_exe),
		.bk_req    (1'b0),
		.bk_done   (1'b0)
	);

	bind backup_copy psx_host_sva i_copy_sva (
		.clk_1x    (clk_1x),
		.rst_n     (rst_n),
		.ram_wr_req(1'b0),
		.ram_wr_ack(1'b0),
		.ioctl_wait(1'b0),
		.load_exe  (1'b0),
		.bk_req    (bk_req),
		.bk_done   (bk_done)
	);

	initial clk_1x = 1'b0;
	always #4 clk_1x = ~clk_1x;

	// ======================================================================
	// reference models
	// ======================================================================

	// expected download write, region base plus the even byte address
	function automatic logic [62:0] dl_ref(input logic [7:0] idx, input logic [26:0] a,
			input logic [15:0] lo, input logic [15:0] hi);
		logic [26:0] base;
		base = (idx == 8'd0) ? psx_host_pkg::bios_base : psx_host_pkg::exe_base;
		return {base + a, hi, lo, 4'hf};
	endfunction

	// all fb_config outputs packed in port order
	function automatic logic [90:0] fb_ref(input logic [63:0] st, input logic [11:0] w,
			input logic [11:0] h, input logic [9:0] ox, input logic [8:0] oy, input logic fsd);
		logic        view;
		logic [1:0]  ar;
		logic [2:0]  sc;
		logic [31:0] base;
		logic [11:0] ax, ay;
		logic [1:0]  sl;
		view = st[11];
		ar   = st[33:32];
		sc   = st[4:2];
		base = psx_host_pkg::fb_base_addr;
		if (!view)
			base = base + 32'(ox) * 2 + 32'(oy) * psx_host_pkg::fb_stride_bytes;
		if (ar == 2'd0) begin
			ax = view ? 12'd2 : 12'd4;
			ay = view ? 12'd1 : 12'd3;
		end else begin
			ax = 12'(ar - 2'd1);
			ay = 12'd0;
		end
		sl = (sc == 3'd0) ? 2'd0 : 2'(sc - 3'd1);
		return {base, st[10] ? 5'b00101 : 5'b01100, view ? 12'd1024 : w, view ? 12'd512 : h,
			ax, ay, st[35:34], sl, sc == 3'd1, (sc != 3'd0) | fsd};
	endfunction

	// unwritten backup words, scrambled from the whole address
	function automatic logic [15:0] backup_fill(input logic [15:0] a);
		return {a[7:0], a[15:8]} ^ 16'ha5c3;
	endfunction

	task automatic check(input logic ok, input string msg);
		check_cnt++;
		assert (ok) else begin
			$display("FAILED @%0t ns: %s", $time, msg);
			err_cnt++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timed out waiting for %s at %0t ns", what, $time);
		err_cnt++;
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		$display("%s: %0d checks, %0d errors", name, check_cnt - chk0, err_cnt - err0);
		chk0 = check_cnt;
		err0 = err_cnt;
	endtask

	// ======================================================================
	// RAM model and compare processes
	// ======================================================================

	initial begin : ram_model
		int d;
		forever begin
			@(posedge clk_1x);
			if (ram_wr_req) begin
				d = 1 + $unsigned($random(seed)) % 6;
				repeat (d) @(negedge clk_1x);
				ram_wr_ack = 1'b1;
				ack_cnt++;
				@(negedge clk_1x);
				ram_wr_ack = 1'b0;
			end
		end
	end

	initial begin : backup_model
		int d;
		forever begin
			@(posedge clk_1x);
			if (bk_req) begin
				d = 1 + $unsigned($random(seed)) % 6;
				repeat (d) @(negedge clk_1x);
				if (bk_loading)
					bk_mem[bk_addr] = bk_wdata;
				else
					bk_rdata = bk_mem.exists(bk_addr) ? bk_mem[bk_addr] : backup_fill(bk_addr);
				bk_ack = 1'b1;
				@(negedge clk_1x);
				bk_ack = 1'b0;
			end
		end
	end

	always @(posedge clk_1x) begin
		if (ram_wr_req) begin
			wr_cnt++;
			check(exp_q.size() != 0, "RAM write request with nothing expected");
			if (exp_q.size() != 0)
				check({ram_wr_addr, ram_wr_data, ram_wr_be} == exp_q[0], $sformatf(
					"write got %h expected %h", {ram_wr_addr, ram_wr_data, ram_wr_be}, exp_q[0]));
			if (exp_q.size() != 0)
				void'(exp_q.pop_front());
		end
		if (bk_req) begin
			check(bk_addr == {cur_sector, 8'(bk_idx)}, $sformatf("bk_addr %h for word %0d",
				bk_addr, bk_idx));
			if (bk_loading && bk_idx < 256)
				check(bk_wdata == sd_data[bk_idx], $sformatf("bk_wdata %h for word %0d",
					bk_wdata, bk_idx));
			bk_idx++;
		end
		if (load_exe)
			exe_pulses++;
	end

	// ======================================================================
	// stimulus tasks
	// ======================================================================

	task automatic download(input logic [7:0] idx, input int pairs);
		logic [15:0] lo, hi;
		logic [26:0] a;
		int          i, t;
		@(negedge clk_1x);
		ioctl_index    = idx;
		ioctl_download = 1'b1;
		for (i = 0; i < pairs; i++) begin
			lo = $random(seed);
			hi = $random(seed);
			a  = 27'(i * 4);
			exp_q.push_back(dl_ref(idx, a, lo, hi));
			@(negedge clk_1x);
			ioctl_addr = a;
			ioctl_dout = lo;
			ioctl_wr   = 1'b1;
			@(negedge clk_1x);
			ioctl_addr = a | 27'd2;
			ioctl_dout = hi;
			@(negedge clk_1x);
			ioctl_wr = 1'b0;
			check(ioctl_wait, "ioctl_wait low right after the odd half");
			t = 0;
			while (ioctl_wait && t < 20) begin
				@(negedge clk_1x);
				t++;
			end
			if (ioctl_wait)
				report_timeout("ioctl_wait to fall");
			// wait must not drop before the RAM took the word
			check(ack_cnt == wr_cnt, $sformatf("wait fell with %0d acks for %0d writes",
				ack_cnt, wr_cnt));
		end
		@(negedge clk_1x);
		ioctl_download = 1'b0;
	endtask

	task automatic core_write(input logic [26:0] a, input logic [31:0] d, input logic [3:0] be);
		int t;
		exp_q.push_back({a, d, be});
		@(negedge clk_1x);
		core_wr_addr = a;
		core_wr_data = d;
		core_wr_be   = be;
		core_wr_req  = 1'b1;
		@(negedge clk_1x);
		core_wr_req = 1'b0;
		t = 0;
		do begin
			@(posedge clk_1x);
			t++;
		end while (!ram_wr_ack && t < 20);
		if (!ram_wr_ack)
			report_timeout("ack of a core write");
	endtask

	task automatic run_copy(input logic [7:0] sector, input logic loading);
		int t;
		@(negedge clk_1x);
		cur_sector = sector;
		bk_idx     = 0;
		bk_sector  = sector;
		bk_loading = loading;
		bk_start   = 1'b1;
		t = 0;
		while (!bk_done && t < 2560) begin
			@(negedge clk_1x);
			t++;
		end
		if (!bk_done)
			report_timeout("bk_done");
		@(negedge clk_1x);
		// done holds while start is still high
		check(bk_done, "bk_done dropped while bk_start is high");
		check(bk_idx == 256, $sformatf("copy issued %0d requests", bk_idx));
		bk_start = 1'b0;
		@(negedge clk_1x);
		check(!bk_done, "bk_done still high after bk_start fell");
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================

	initial begin
		int          i, n0, p0;
		logic [90:0] got;
		rst_n = 1'b0;
		{ioctl_download, ioctl_index, ioctl_addr, ioctl_dout, ioctl_wr, ram_wr_ack} = '0;
		{core_wr_addr, core_wr_data, core_wr_be, core_wr_req} = '0;
		{bk_start, bk_loading, bk_sector, bk_ack, bk_rdata} = '0;
		{sd_buff_addr, sd_buff_dout, sd_buff_wr} = '0;
		{status, disp_width, disp_height, disp_off_x, disp_off_y, forced_scandoubler} = '0;
		repeat (2) @(negedge clk_1x);
		rst_n = 1'b1;

		@(posedge clk_1x);
		check({ioctl_wait, ram_wr_req, load_exe, bk_req, bk_done} == 5'b0,
			"control outputs not low after reset");
		end_test("reset");

		n0 = wr_cnt;
		download(8'd0, 8);
		@(posedge clk_1x);
		check(wr_cnt - n0 == 8 && exp_q.size() == 0, "bios write count wrong");
		check(!cart_loaded, "cart_loaded set by a bios download");
		end_test("bios_download");

		// exe download, then load_exe on the second edge after the fall
		p0 = exe_pulses;
		download(8'd3, 8);
		@(posedge clk_1x);
		check(!load_exe, "load_exe early, first edge");
		@(posedge clk_1x);
		check(!load_exe, "load_exe early, second edge");
		@(posedge clk_1x);
		check(load_exe, "load_exe missing");
		@(posedge clk_1x);
		check(!load_exe && exe_pulses - p0 == 1, "load_exe not a single pulse");
		check(cart_loaded, "cart_loaded not set after exe download");
		for (i = 0; i < 4; i++)
			core_write(27'($random(seed)), $random(seed), 4'($random(seed)));
		check(exp_q.size() == 0, "core write lost");
		end_test("exe_and_core");

		n0 = wr_cnt;
		download(8'd7, 32);
		repeat (4) @(posedge clk_1x);
		check(wr_cnt - n0 == 32 && exp_q.size() == 0, "writes lost or doubled");
		end_test("ack_backpressure");

		// sd data in through port b, then a loading and a saving copy
		for (i = 0; i < 256; i++) begin
			sd_data[i] = $random(seed);
			@(negedge clk_1x);
			sd_buff_addr = 8'(i);
			sd_buff_dout = sd_data[i];
			sd_buff_wr   = 1'b1;
		end
		@(negedge clk_1x);
		sd_buff_wr = 1'b0;
		run_copy(8'h12, 1'b1);
		run_copy(8'h34, 1'b0);
		for (i = 0; i < 256; i++) begin
			@(negedge clk_1x);
			sd_buff_addr = 8'(i);
			@(posedge clk_1x);
			check(sd_buff_din == backup_fill({8'h34, 8'(i)}), $sformatf(
				"saved word %0d reads %h", i, sd_buff_din));
		end
		end_test("backup_copy");

		for (i = 0; i < 40; i++) begin
			@(negedge clk_1x);
			status[63:32]      = $random(seed);
			status[31:0]       = $random(seed);
			status[4:2]        = 3'($unsigned($random(seed)) % 5);
			disp_width         = 12'($random(seed));
			disp_height        = 12'($random(seed));
			disp_off_x         = 10'($random(seed));
			disp_off_y         = 9'($random(seed));
			forced_scandoubler = 1'($random(seed));
			@(posedge clk_1x);
			got = {fb_base, fb_format, fb_width, fb_height, arx, ary, vscale, scanline, hq2x,
				scandoubler};
			check(got == fb_ref(status, disp_width, disp_height, disp_off_x, disp_off_y,
				forced_scandoubler), $sformatf("fb_config status %h gives %h", status, got));
		end
		end_test("fb_config");

		$display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		repeat (total_words * 20 + 500) @(posedge clk_1x);
		$display("watchdog expired, the run did not finish in time");
		$display("Test failed");
		$finish;
	end

endmodule

// ==== psx_host_sva.sv ====
// handshake checks only; inputs a bound block lacks are tied low at the bind
module psx_host_sva (
	input logic clk_1x,
	input logic rst_n,
	input logic ram_wr_req,
	input logic ram_wr_ack,
	input logic ioctl_wait,
	input logic load_exe,
	input logic bk_req,
	input logic bk_done
);
	timeunit 1ns;
	timeprecision 1ps;

	// ======================================================================
	// loader
	// ======================================================================

	// one cycle per request
	a_req_pulse : assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr_req |=> !ram_wr_req)
		else $error("ram_wr_req held longer than one cycle");

	// wait released only by the ram ack
	a_wait_fall : assert property (@(posedge clk_1x) disable iff (!rst_n)
		$fell(ioctl_wait) |-> $past(ram_wr_ack))
		else $error("ioctl_wait fell without a ram_wr_ack");

	a_exe_pulse : assert property (@(posedge clk_1x) disable iff (!rst_n)
		load_exe |=> !load_exe)
		else $error("load_exe longer than one cycle");

	// ======================================================================
	// copy sequencer
	// ======================================================================

	a_no_req_done : assert property (@(posedge clk_1x) disable iff (!rst_n)
		!(bk_req && bk_done))
		else $error("bk_req issued while bk_done is high");

endmodule

// ==== psx_host_top.sv ====
// host glue around the core; ram is external and seen only through req and ack pulses
module psx_host_top #(
	parameter logic [psx_host_pkg::ram_addr_w-1:0] bios_base = psx_host_pkg::bios_base,
	parameter logic [psx_host_pkg::ram_addr_w-1:0] exe_base  = psx_host_pkg::exe_base,
	parameter logic [31:0] fb_base_addr    = psx_host_pkg::fb_base_addr,
	parameter int          fb_stride_bytes = psx_host_pkg::fb_stride_bytes,
	parameter int          bk_words_log2   = psx_host_pkg::bk_words_log2
) (
	input  logic                                clk_1x,
	input  logic                                rst_n,

	// download port
	input  logic                                ioctl_download,
	input  logic [7:0]                          ioctl_index,
	input  logic [psx_host_pkg::ram_addr_w-1:0] ioctl_addr,
	input  logic [15:0]                         ioctl_dout,
	input  logic                                ioctl_wr,
	output logic                                ioctl_wait,

	// ram write channel and core writes
	output logic [psx_host_pkg::ram_addr_w-1:0] ram_wr_addr,
	output logic [31:0]                         ram_wr_data,
	output logic [3:0]                          ram_wr_be,
	output logic                                ram_wr_req,
	input  logic                                ram_wr_ack,
	input  logic [psx_host_pkg::ram_addr_w-1:0] core_wr_addr,
	input  logic [31:0]                         core_wr_data,
	input  logic [3:0]                          core_wr_be,
	input  logic                                core_wr_req,
	output logic                                load_exe,
	output logic                                cart_loaded,

	// backup copy
	input  logic                                bk_start,
	input  logic                                bk_loading,
	input  logic [7:0]                          bk_sector,
	output logic                                bk_req,
	output logic [15:0]                         bk_addr,
	output logic [15:0]                         bk_wdata,
	input  logic                                bk_ack,
	input  logic [15:0]                         bk_rdata,
	output logic                                bk_done,

	// sd sector buffer port
	input  logic [bk_words_log2-1:0]            sd_buff_addr,
	input  logic [15:0]                         sd_buff_dout,
	input  logic                                sd_buff_wr,
	output logic [15:0]                         sd_buff_din,

	// video configuration
	input  logic [63:0]                         status,
	input  logic [11:0]                         disp_width,
	input  logic [11:0]                         disp_height,
	input  logic [9:0]                          disp_off_x,
	input  logic [8:0]                          disp_off_y,
	input  logic                                forced_scandoubler,
	output logic [31:0]                         fb_base,
	output logic [4:0]                          fb_format,
	output logic [11:0]                         fb_width,
	output logic [11:0]                         fb_height,
	output logic [11:0]                         arx,
	output logic [11:0]                         ary,
	output logic [1:0]                          vscale,
	output logic [1:0]                          scanline,
	output logic                                hq2x,
	output logic                                scandoubler
);

	// buffer port a, sequencer side
	logic [bk_words_log2-1:0] buf_addr;
	logic                     buf_we;
	logic [15:0]              buf_dout;

	rom_loader #(
		.bios_base(bios_base),
		.exe_base (exe_base)
	) i_rom_loader (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.ioctl_download(ioctl_download),
		.ioctl_index   (ioctl_index),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.ioctl_wr      (ioctl_wr),
		.ioctl_wait    (ioctl_wait),
		.ram_wr_addr   (ram_wr_addr),
		.ram_wr_data   (ram_wr_data),
		.ram_wr_be     (ram_wr_be),
		.ram_wr_req    (ram_wr_req),
		.ram_wr_ack    (ram_wr_ack),
		.core_wr_addr  (core_wr_addr),
		.core_wr_data  (core_wr_data),
		.core_wr_be    (core_wr_be),
		.core_wr_req   (core_wr_req),
		.load_exe      (load_exe),
		.cart_loaded   (cart_loaded)
	);

	// ram read data is written through port a when saving
	backup_buffer #(
		.bk_words_log2(bk_words_log2)
	) i_backup_buffer (
		.clk_1x(clk_1x),
		.a_addr(buf_addr),
		.a_din (bk_rdata),
		.a_we  (buf_we),
		.a_dout(buf_dout),
		.b_addr(sd_buff_addr),
		.b_din (sd_buff_dout),
		.b_we  (sd_buff_wr),
		.b_dout(sd_buff_din)
	);

	backup_copy #(
		.bk_words_log2(bk_words_log2)
	) i_backup_copy (
		.clk_1x    (clk_1x),
		.rst_n     (rst_n),
		.bk_start  (bk_start),
		.bk_loading(bk_loading),
		.bk_sector (bk_sector),
		.bk_req    (bk_req),
		.bk_addr   (bk_addr),
		.bk_wdata  (bk_wdata),
		.bk_ack    (bk_ack),
		.buf_addr  (buf_addr),
		.buf_we    (buf_we),
		.buf_dout  (buf_dout),
		.bk_done   (bk_done)
	);

	fb_config #(
		.fb_base_addr   (fb_base_addr),
		.fb_stride_bytes(fb_stride_bytes)
	) i_fb_config (
		.status            (status),
		.disp_width        (disp_width),
		.disp_height       (disp_height),
		.disp_off_x        (disp_off_x),
		.disp_off_y        (disp_off_y),
		.forced_scandoubler(forced_scandoubler),
		.fb_base           (fb_base),
		.fb_format         (fb_format),
		.fb_width          (fb_width),
		.fb_height         (fb_height),
		.arx               (arx),
		.ary               (ary),
		.vscale            (vscale),
		.scanline          (scanline),
		.hq2x              (hq2x),
		.scandoubler       (scandoubler)
	);

endmodule

// ==== fb_config.sv ====
// purely combinational; assumes 16 bit pixels for the x offset and scale field values 0..4
module fb_config #(
	parameter logic [31:0] fb_base_addr    = psx_host_pkg::fb_base_addr,
	parameter int          fb_stride_bytes = psx_host_pkg::fb_stride_bytes
) (
	input  logic [63:0] status,
	input  logic [11:0] disp_width,
	input  logic [11:0] disp_height,
	input  logic [9:0]  disp_off_x,
	input  logic [8:0]  disp_off_y,
	input  logic        forced_scandoubler,

	output logic [31:0] fb_base,
	output logic [4:0]  fb_format,
	output logic [11:0] fb_width,
	output logic [11:0] fb_height,
	output logic [11:0] arx,
	output logic [11:0] ary,
	output logic [1:0]  vscale,
	output logic [1:0]  scanline,
	output logic        hq2x,
	output logic        scandoubler
);

	logic        vram_view;
	logic [31:0] off_x_bytes;
	logic [31:0] off_y_bytes;
	logic [psx_host_pkg::st_ar_w-1:0]    ar;
	logic [psx_host_pkg::st_scale_w-1:0] scale;
	logic [psx_host_pkg::st_scale_w-1:0] sl;

	assign vram_view = status[psx_host_pkg::st_vram_view];

	// ======================================================================
	// framebuffer window
	// ======================================================================

	// 2 bytes per pixel, one stride per line
	assign off_x_bytes = {21'd0, disp_off_x, 1'b0};
	assign off_y_bytes = 32'(disp_off_y) * 32'(fb_stride_bytes);

	assign fb_base   = vram_view ? fb_base_addr : fb_base_addr + off_x_bytes + off_y_bytes;
	// 24 bit rgb or 16 bit 1555
	assign fb_format = status[psx_host_pkg::st_color24] ? 5'b00101 : 5'b01100;
	// viewer shows the full 1024 x 512 vram
	assign fb_width  = vram_view ? 12'd1024 : disp_width;
	assign fb_height = vram_view ? 12'd512  : disp_height;

	// ======================================================================
	// aspect and scaler
	// ======================================================================

	assign ar = status[psx_host_pkg::st_ar_lo +: psx_host_pkg::st_ar_w];

	// original ratio, 4:3 or 2:1 for the viewer
	assign arx = (ar == '0) ? (vram_view ? 12'd2 : 12'd4) : 12'(ar - 1'b1);
	assign ary = (ar == '0) ? (vram_view ? 12'd1 : 12'd3) : 12'd0;

	assign vscale = status[psx_host_pkg::st_vscale_lo +: psx_host_pkg::st_vscale_w];

	assign scale = status[psx_host_pkg::st_scale_lo +: psx_host_pkg::st_scale_w];

	// none, hq2x, then crt 25/50/75
	assign sl          = (scale != '0) ? scale - 1'b1 : '0;
	assign scanline    = sl[1:0];
	assign hq2x        = (scale == 3'd1);
	assign scandoubler = (scale != '0) | forced_scandoubler;

endmodule

// ==== backup_copy.sv ====
// one sector per bk_start level; bk_start must drop before the next sector, ack follows each req
module backup_copy #(
	parameter int bk_words_log2 = psx_host_pkg::bk_words_log2
) (
	input  logic                     clk_1x,
	input  logic                     rst_n,

	// control from the save logic
	input  logic                     bk_start,
	input  logic                     bk_loading,
	input  logic [7:0]               bk_sector,

	// ram side
	output logic                     bk_req,
	output logic [15:0]              bk_addr,
	output logic [15:0]              bk_wdata,
	input  logic                     bk_ack,

	// buffer port a
	output logic [bk_words_log2-1:0] buf_addr,
	output logic                     buf_we,
	input  logic [15:0]              buf_dout,

	output logic                     bk_done
);

	logic [bk_words_log2-1:0] word_cnt;
	// a request is outstanding
	logic                     waiting;

	// ======================================================================
	// sequencer
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			word_cnt <= '0;
			waiting  <= 1'b0;
			bk_req   <= 1'b0;
			bk_done  <= 1'b0;
		end else begin
			bk_req <= 1'b0;
			if (!bk_start) begin
				// idle, rewind to word 0
				word_cnt <= '0;
				waiting  <= 1'b0;
				bk_done  <= 1'b0;
			end else if (!bk_done) begin
				if (!waiting) begin
					// first word of the sector
					bk_req  <= 1'b1;
					waiting <= 1'b1;
				end else if (bk_ack) begin
					if (&word_cnt) begin
						waiting <= 1'b0;
						bk_done <= 1'b1;
					end else begin
						// next word right behind the ack
						word_cnt <= word_cnt + 1'b1;
						bk_req   <= 1'b1;
					end
				end
			end
		end
	end

	// ======================================================================
	// addressing and data
	// ======================================================================

	// sector number on top of the word index
	assign bk_addr  = {bk_sector, word_cnt};
	assign buf_addr = word_cnt;

	// loading: buffer word goes out to ram
	assign bk_wdata = buf_dout;

	// saving: read data lands in the buffer on its ack
	assign buf_we = ~bk_loading & waiting & bk_ack;

endmodule

// ==== backup_buffer.sv ====
// async read ports; a same-address write on both ports in one cycle keeps port b's data
module backup_buffer #(
	parameter int bk_words_log2 = psx_host_pkg::bk_words_log2
) (
	input  logic                     clk_1x,

	// port a, copy sequencer
	input  logic [bk_words_log2-1:0] a_addr,
	input  logic [15:0]              a_din,
	input  logic                     a_we,
	output logic [15:0]              a_dout,

	// port b, sd sector port
	input  logic [bk_words_log2-1:0] b_addr,
	input  logic [15:0]              b_din,
	input  logic                     b_we,
	output logic [15:0]              b_dout
);

	// one sector of backup data
	logic [15:0] mem [2**bk_words_log2];

	// no reset on storage
	always_ff @(posedge clk_1x) begin
		if (a_we)
			mem[a_addr] <= a_din;
		// b last, wins a collision
		if (b_we)
			mem[b_addr] <= b_din;
	end

	// ======================================================================
	// read side
	// ======================================================================

	// new data during a write to the same word
	assign a_dout = a_we ? a_din : mem[a_addr];
	assign b_dout = b_we ? b_din : mem[b_addr];

endmodule

// ==== rom_loader.sv ====
// index 0 is bios, 1..254 executable, 255 ignored; host must hold ioctl_wr low while ioctl_wait is high
module rom_loader #(
	parameter logic [psx_host_pkg::ram_addr_w-1:0] bios_base = psx_host_pkg::bios_base,
	parameter logic [psx_host_pkg::ram_addr_w-1:0] exe_base  = psx_host_pkg::exe_base
) (
	input  logic                                clk_1x,
	input  logic                                rst_n,

	// download stream from the host
	input  logic                                ioctl_download,
	input  logic [7:0]                          ioctl_index,
	input  logic [psx_host_pkg::ram_addr_w-1:0] ioctl_addr,
	input  logic [15:0]                         ioctl_dout,
	input  logic                                ioctl_wr,
	output logic                                ioctl_wait,

	// ram write channel
	output logic [psx_host_pkg::ram_addr_w-1:0] ram_wr_addr,
	output logic [31:0]                         ram_wr_data,
	output logic [3:0]                          ram_wr_be,
	output logic                                ram_wr_req,
	input  logic                                ram_wr_ack,

	// core side of the write channel
	input  logic [psx_host_pkg::ram_addr_w-1:0] core_wr_addr,
	input  logic [31:0]                         core_wr_data,
	input  logic [3:0]                          core_wr_be,
	input  logic                                core_wr_req,

	output logic                                load_exe,
	output logic                                cart_loaded
);

	// ======================================================================
	// download type
	// ======================================================================

	logic bios_download;
	logic cart_download;
	logic cart_download_1;
	logic dl_active;

	// flags lag ioctl_download by one cycle
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			bios_download <= 1'b0;
			cart_download <= 1'b0;
		end else begin
			bios_download <= ioctl_download & (ioctl_index == 8'd0);
			cart_download <= ioctl_download & (ioctl_index != 8'd0) & (ioctl_index != 8'hff);
		end
	end

	assign dl_active = bios_download | cart_download;

	// ======================================================================
	// half-word packing and wait
	// ======================================================================

	psx_host_pkg::dl_word_u              dl_word;
	logic [psx_host_pkg::ram_addr_w-1:0] dl_addr;
	logic                                dl_req;

	// payload, no reset
	always_ff @(posedge clk_1x) begin
		if (dl_active && ioctl_wr) begin
			if (!ioctl_addr[1]) begin
				dl_word.half[0] <= ioctl_dout;
				// word address taken from the even half
				dl_addr <= ioctl_addr + (bios_download ? bios_base : exe_base);
			end else begin
				dl_word.half[1] <= ioctl_dout;
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			dl_req     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			dl_req <= 1'b0;
			if (dl_active) begin
				// wait drops the cycle after the ram takes the word
				if (ram_wr_ack)
					ioctl_wait <= 1'b0;
				// odd half completes the word
				if (ioctl_wr && ioctl_addr[1]) begin
					dl_req     <= 1'b1;
					ioctl_wait <= 1'b1;
				end
			end else begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// ======================================================================
	// executable done strobe
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			cart_download_1 <= 1'b0;
			load_exe        <= 1'b0;
			cart_loaded     <= 1'b0;
		end else begin
			cart_download_1 <= cart_download;
			load_exe        <= cart_download_1 & ~cart_download;
			// sticky once any exe came in
			if (cart_download)
				cart_loaded <= 1'b1;
		end
	end

	// ======================================================================
	// write channel mux
	// ======================================================================

	// download owns the channel, full word writes
	assign ram_wr_addr = dl_active ? dl_addr      : core_wr_addr;
	assign ram_wr_data = dl_active ? dl_word.word : core_wr_data;
	assign ram_wr_be   = dl_active ? 4'b1111      : core_wr_be;
	assign ram_wr_req  = dl_active ? dl_req       : core_wr_req;

endmodule

// ==== psx_host_pkg.sv ====
// shared constants for the host glue; RAM is byte addressed, 27 bits, status word is 64 bits
package psx_host_pkg;

	// ======================================================================
	// RAM map
	// ======================================================================

	// byte address width of the RAM channel
	parameter int ram_addr_w = 27;

	// download regions, byte offsets
	parameter logic [ram_addr_w-1:0] bios_base = 27'd2097152;
	parameter logic [ram_addr_w-1:0] exe_base  = 27'd4194304;

	// ======================================================================
	// framebuffer
	// ======================================================================

	// start of the framebuffer in board memory
	parameter logic [31:0] fb_base_addr = 32'h3000_0000;

	// one line of vram, 1024 pixels at 2 bytes
	parameter int fb_stride_bytes = 2048;

	// ======================================================================
	// backup ram buffer
	// ======================================================================

	// 256 words of 16 bits, one sd sector
	parameter int bk_words_log2 = 8;

	// ======================================================================
	// status word bit positions
	// ======================================================================

	// pixel format select, set means 24 bit
	parameter int st_color24   = 10;
	// whole vram shown instead of display area
	parameter int st_vram_view = 11;

	// scandoubler fx field
	parameter int st_scale_lo  = 2;
	parameter int st_scale_w   = 3;

	// aspect ratio field
	parameter int st_ar_lo     = 32;
	parameter int st_ar_w      = 2;

	// vertical scale mode field
	parameter int st_vscale_lo = 34;
	parameter int st_vscale_w  = 2;

	// one download word
	// written as two halves, low half at the even address first
	typedef union packed {
		logic [1:0][15:0] half;
		logic [31:0]      word;
	} dl_word_u;

endpackage
